/* source/core_pkg.sv */
/*
 * core package
 *   word, register-number and field typedefs
 *   ALU operation and exception code enums
 *   opcode and funct encodings of the supported instructions
 */
`timescale 1ns/1ps
`default_nettype none

package core_pkg;

    localparam int WORD_W = 32;
    localparam int REG_AW = 5;

    typedef logic [WORD_W-1:0] word_t;      // data or instruction word
    typedef logic [REG_AW-1:0] reg_addr_t;  // register number
    typedef logic [5:0]        opcode_t;    // bits 31:26
    typedef logic [5:0]        funct_t;     // bits 5:0 of R-type

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_e;

    typedef enum logic [1:0] {
        EXC_NONE     = 2'd0,
        EXC_ILLEGAL  = 2'd1,  // raised in decode
        EXC_OVERFLOW = 2'd2   // raised in execute
    } exc_e;

    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_ADDI  = 6'h08;

    localparam funct_t FN_ADD = 6'h20;
    localparam funct_t FN_SUB = 6'h22;
    localparam funct_t FN_AND = 6'h24;
    localparam funct_t FN_OR  = 6'h25;
    localparam funct_t FN_SLT = 6'h2a;

endpackage

`default_nettype wire

/* source/pipe_ifs.sv */
/*
 * stage-to-stage interfaces
 *   exec_if    decode to execute, operands and control
 *   retire_if  execute to writeback, result and control
 */
`timescale 1ns/1ps
`default_nettype none

interface exec_if
    import core_pkg::*;
    ();

    logic      valid;
    logic      ready;
    alu_op_e   alu_op;
    word_t     operand_a;
    word_t     operand_b;   // rt value or sign-extended immediate
    reg_addr_t dest;
    logic      write_en;
    exc_e      exc;

    modport source (output valid, alu_op, operand_a, operand_b, dest, write_en, exc,
                    input  ready);
    modport sink   (input  valid, alu_op, operand_a, operand_b, dest, write_en, exc,
                    output ready);

endinterface

interface retire_if
    import core_pkg::*;
    ();

    logic      valid;
    logic      ready;
    word_t     result;
    reg_addr_t dest;
    logic      write_en;    // already cleared on any exception
    exc_e      exc;

    modport source (output valid, result, dest, write_en, exc, input ready);
    modport sink   (input  valid, result, dest, write_en, exc, output ready);

endinterface

`default_nettype wire

/* source/reg_file.sv */
/*
 * register file
 *   31 writable words, register zero reads as zero
 *   two combinational read ports, one write port
 */
`timescale 1ns/1ps
`default_nettype none

module reg_file
    import core_pkg::*;
(
    input  wire logic      SYS_clk,
    input  wire logic      SYS_reset,
    input  wire reg_addr_t rd_addr_a,
    input  wire reg_addr_t rd_addr_b,
    input  wire logic      wr_en,
    input  wire reg_addr_t wr_addr,
    input  wire word_t     wr_data,
    output word_t          rd_data_a,
    output word_t          rd_data_b
);

    word_t regs [1:31];  // no storage behind register zero

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            for (int i = 1; i < 32; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr_en && wr_addr != '0)
        begin
            regs[wr_addr] <= wr_data;
        end
    end

    // old value on a same-edge write
    assign rd_data_a = (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
    assign rd_data_b = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];

endmodule

`default_nettype wire

/* source/decode_stage.sv */
/*
 * decode stage
 *   instruction register on the input stream
 *   field split, ALU op select, immediate sign extension
 *   illegal instruction check
 *   hazard stall against execute, forwarding from writeback
 */
`timescale 1ns/1ps
`default_nettype none

module decode_stage
    import core_pkg::*;
(
    input  wire logic      SYS_clk,
    input  wire logic      SYS_reset,
    input  wire logic      instr_valid,
    input  wire word_t     instr,
    input  wire word_t     rd_data_a,
    input  wire word_t     rd_data_b,
    input  wire logic      fwd_valid,
    input  wire reg_addr_t fwd_dest,
    input  wire word_t     fwd_data,
    input  wire logic      ex_busy,
    input  wire reg_addr_t ex_dest,
    output logic           instr_ready,
    output reg_addr_t      rd_addr_a,
    output reg_addr_t      rd_addr_b,
    exec_if.source         ex_out
);

    logic      run_q;     // low until the first edge after reset
    logic      valid_q;
    word_t     instr_q;
    opcode_t   opcode;
    funct_t    funct;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    logic      is_rtype;
    logic      legal;
    logic      hazard;
    alu_op_e   alu_op;
    word_t     imm_ext;
    word_t     src_a;
    word_t     src_b;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            run_q   <= 1'b0;
            valid_q <= 1'b0;
            instr_q <= '0;
        end
        else
        begin
            run_q <= 1'b1;
            if (instr_valid && instr_ready)
            begin
                valid_q <= 1'b1;
                instr_q <= instr;
            end
            else if (ex_out.valid && ex_out.ready)
            begin
                valid_q <= 1'b0;
            end
        end
    end

    assign opcode   = instr_q[31:26];
    assign rs       = instr_q[25:21];
    assign rt       = instr_q[20:16];
    assign rd       = instr_q[15:11];
    assign funct    = instr_q[5:0];
    assign imm_ext  = {{16{instr_q[15]}}, instr_q[15:0]};
    assign is_rtype = (opcode == OP_RTYPE);

    always_comb
    begin
        alu_op = ALU_ADD;  // addi and the illegal default
        legal  = 1'b1;
        if (is_rtype)
        begin
            case (funct)
                FN_ADD:  alu_op = ALU_ADD;
                FN_SUB:  alu_op = ALU_SUB;
                FN_AND:  alu_op = ALU_AND;
                FN_OR:   alu_op = ALU_OR;
                FN_SLT:  alu_op = ALU_SLT;
                default: legal  = 1'b0;
            endcase
        end
        else if (opcode != OP_ADDI)
        begin
            legal = 1'b0;
        end
    end

    // producer still in execute, wait for it to reach writeback
    assign hazard = ex_busy && ((ex_dest == rs) || (is_rtype && ex_dest == rt));

    assign rd_addr_a = rs;
    assign rd_addr_b = rt;

    assign src_a = (fwd_valid && rs != '0 && fwd_dest == rs) ? fwd_data : rd_data_a;
    assign src_b = (fwd_valid && rt != '0 && fwd_dest == rt) ? fwd_data : rd_data_b;

    assign ex_out.valid     = valid_q && !hazard;
    assign ex_out.alu_op    = alu_op;
    assign ex_out.operand_a = src_a;
    assign ex_out.operand_b = is_rtype ? src_b : imm_ext;
    assign ex_out.dest      = is_rtype ? rd : rt;
    assign ex_out.write_en  = legal && (ex_out.dest != '0);  // r0 writes dropped
    assign ex_out.exc       = legal ? EXC_NONE : EXC_ILLEGAL;

    assign instr_ready = run_q && (!valid_q || (ex_out.valid && ex_out.ready));

endmodule

`default_nettype wire

/* source/execute_stage.sv */
/*
 * execute stage
 *   operand register
 *   ALU for add, sub, and, or and signed slt
 *   signed overflow detection on add and sub
 */
`timescale 1ns/1ps
`default_nettype none

module execute_stage
    import core_pkg::*;
(
    input  wire logic SYS_clk,
    input  wire logic SYS_reset,
    exec_if.sink      ex_in,
    retire_if.source  rt_out,
    output logic      ex_busy,
    output reg_addr_t ex_dest
);

    logic      valid_q;
    alu_op_e   alu_op_q;
    word_t     a_q;
    word_t     b_q;
    reg_addr_t dest_q;
    logic      wen_q;
    exc_e      exc_q;
    word_t     sum;
    word_t     diff;
    word_t     result;
    logic      ovf;
    exc_e      exc;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            valid_q  <= 1'b0;
            alu_op_q <= ALU_ADD;
            a_q      <= '0;
            b_q      <= '0;
            dest_q   <= '0;
            wen_q    <= 1'b0;
            exc_q    <= EXC_NONE;
        end
        else if (ex_in.valid && ex_in.ready)
        begin
            valid_q  <= 1'b1;
            alu_op_q <= ex_in.alu_op;
            a_q      <= ex_in.operand_a;
            b_q      <= ex_in.operand_b;
            dest_q   <= ex_in.dest;
            wen_q    <= ex_in.write_en;
            exc_q    <= ex_in.exc;
        end
        else if (rt_out.valid && rt_out.ready)
        begin
            valid_q <= 1'b0;
        end
    end

    assign sum  = a_q + b_q;
    assign diff = a_q - b_q;

    always_comb
    begin
        ovf = 1'b0;
        case (alu_op_q)
            ALU_ADD:
            begin
                result = sum;
                ovf    = (a_q[31] == b_q[31]) && (sum[31] != a_q[31]);
            end
            ALU_SUB:
            begin
                result = diff;
                ovf    = (a_q[31] != b_q[31]) && (diff[31] != a_q[31]);
            end
            ALU_AND: result = a_q & b_q;
            ALU_OR:  result = a_q | b_q;
            ALU_SLT: result = {31'b0, $signed(a_q) < $signed(b_q)};
            default: result = '0;
        endcase
    end

    // an earlier code wins over overflow
    assign exc = (exc_q != EXC_NONE) ? exc_q : (ovf ? EXC_OVERFLOW : EXC_NONE);

    assign rt_out.valid    = valid_q;
    assign rt_out.result   = result;
    assign rt_out.dest     = dest_q;
    assign rt_out.write_en = wen_q && (exc == EXC_NONE);
    assign rt_out.exc      = exc;

    assign ex_in.ready = !valid_q || (rt_out.valid && rt_out.ready);

    assign ex_busy = valid_q && wen_q;  // may stall on an overflow too
    assign ex_dest = dest_q;

endmodule

`default_nettype wire

/* source/writeback_stage.sv */
/*
 * writeback stage
 *   retire register and commit stream
 *   register file write on commit
 *   forwarding view for decode
 */
`timescale 1ns/1ps
`default_nettype none

module writeback_stage
    import core_pkg::*;
(
    input  wire logic SYS_clk,
    input  wire logic SYS_reset,
    input  wire logic commit_ready,
    retire_if.sink    rt_in,
    output logic      commit_valid,
    output reg_addr_t commit_dest,
    output word_t     commit_data,
    output exc_e      commit_exc,
    output logic      wr_en,
    output reg_addr_t wr_addr,
    output word_t     wr_data,
    output logic      fwd_valid,
    output reg_addr_t fwd_dest,
    output word_t     fwd_data
);

    logic      valid_q;
    word_t     data_q;    // zero when an exception is carried
    reg_addr_t dest_q;
    logic      wen_q;
    exc_e      exc_q;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            valid_q <= 1'b0;
            data_q  <= '0;
            dest_q  <= '0;
            wen_q   <= 1'b0;
            exc_q   <= EXC_NONE;
        end
        else if (rt_in.valid && rt_in.ready)
        begin
            valid_q <= 1'b1;
            data_q  <= (rt_in.exc == EXC_NONE) ? rt_in.result : '0;
            dest_q  <= rt_in.dest;
            wen_q   <= rt_in.write_en;
            exc_q   <= rt_in.exc;
        end
        else if (commit_valid && commit_ready)
        begin
            valid_q <= 1'b0;
        end
    end

    assign rt_in.ready = !valid_q || (commit_valid && commit_ready);

    assign commit_valid = valid_q;
    assign commit_dest  = dest_q;
    assign commit_data  = data_q;
    assign commit_exc   = exc_q;

    assign wr_en   = valid_q && commit_ready && wen_q;  // only on the commit transfer
    assign wr_addr = dest_q;
    assign wr_data = data_q;

    assign fwd_valid = valid_q && wen_q;
    assign fwd_dest  = dest_q;
    assign fwd_data  = data_q;

endmodule

`default_nettype wire

/* source/mips_core.sv */
/*
 * core top level
 *   decode, execute and writeback stages
 *   register file and the two stage interfaces
 */
`timescale 1ns/1ps
`default_nettype none

module mips_core
    import core_pkg::*;
(
    input  wire logic      SYS_clk,
    input  wire logic      SYS_reset,
    input  wire logic      instr_valid,
    output logic           instr_ready,
    input  wire word_t     instr,
    output logic           commit_valid,
    input  wire logic      commit_ready,
    output reg_addr_t      commit_dest,
    output word_t          commit_data,
    output exc_e           commit_exc
);

    reg_addr_t rd_addr_a;
    reg_addr_t rd_addr_b;
    word_t     rd_data_a;
    word_t     rd_data_b;
    logic      wr_en;
    reg_addr_t wr_addr;
    word_t     wr_data;
    logic      fwd_valid;
    reg_addr_t fwd_dest;
    word_t     fwd_data;
    logic      ex_busy;
    reg_addr_t ex_dest;

    exec_if   u_exec_if ();
    retire_if u_retire_if ();

    decode_stage u_decode (
        .SYS_clk     (SYS_clk),
        .SYS_reset   (SYS_reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rd_data_a   (rd_data_a),
        .rd_data_b   (rd_data_b),
        .fwd_valid   (fwd_valid),
        .fwd_dest    (fwd_dest),
        .fwd_data    (fwd_data),
        .ex_busy     (ex_busy),
        .ex_dest     (ex_dest),
        .instr_ready (instr_ready),
        .rd_addr_a   (rd_addr_a),
        .rd_addr_b   (rd_addr_b),
        .ex_out      (u_exec_if.source)
    );

    execute_stage u_execute (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .ex_in     (u_exec_if.sink),
        .rt_out    (u_retire_if.source),
        .ex_busy   (ex_busy),
        .ex_dest   (ex_dest)
    );

    writeback_stage u_writeback (
        .SYS_clk      (SYS_clk),
        .SYS_reset    (SYS_reset),
        .commit_ready (commit_ready),
        .rt_in        (u_retire_if.sink),
        .commit_valid (commit_valid),
        .commit_dest  (commit_dest),
        .commit_data  (commit_data),
        .commit_exc   (commit_exc),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .fwd_valid    (fwd_valid),
        .fwd_dest     (fwd_dest),
        .fwd_data     (fwd_data)
    );

    reg_file u_reg_file (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b)
    );

endmodule

`default_nettype wire

/* bench/commit_checker.sv */
/*
 * commit checker
 *   loads the expected commits from the pattern file
 *   compares every commit transfer in order
 *   per-test result lines and a closing count line
 */
`timescale 1ns/1ps
`default_nettype none

module commit_checker
    import core_pkg::*;
(
    input  wire logic      SYS_clk,
    input  wire logic      SYS_reset,
    input  wire logic      commit_valid,
    input  wire logic      commit_ready,
    input  wire reg_addr_t commit_dest,
    input  wire word_t     commit_data,
    input  wire exc_e      commit_exc,
    input  wire logic      report,
    output logic           done,
    output int             errors
);

    localparam int MAX_PAT = 64;

    logic [31:0] pat_mem [0:5*MAX_PAT-1];  // five columns per line
    int          pat_count;
    int          idx;
    int          test_errs;
    int          test_commits;
    logic        reported;

    initial
    begin
        $readmemh("bench/core_patterns.txt", pat_mem);
        pat_count = 0;
        // list ends at a zero or unread test number
        while (pat_count < MAX_PAT && !$isunknown(pat_mem[5*pat_count]) &&
               pat_mem[5*pat_count] != '0)
        begin
            pat_count++;
        end
    end

    assign done = (pat_count > 0) && (idx == pat_count);

    always @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            idx          <= 0;
            errors       <= 0;
            test_errs    <= 0;
            test_commits <= 0;
            reported     <= 1'b0;
        end
        else if (report && !reported)
        begin
            reported <= 1'b1;
            if (idx < pat_count)
            begin
                $display("missing commits: only %0d of %0d instructions committed",
                         idx, pat_count);
                errors <= errors + 1;
            end
            $display("checked %0d of %0d commits, %0d errors", idx, pat_count,
                     errors + ((idx < pat_count) ? 1 : 0));
        end
        else if (commit_valid && commit_ready)
        begin
            if (idx >= pat_count)
            begin
                $display("unexpected extra commit after the last expected one, dest %0d",
                         commit_dest);
                errors <= errors + 1;
            end
            else
            begin
                if (commit_dest != pat_mem[5*idx+2][4:0] ||
                    commit_data != pat_mem[5*idx+3] ||
                    commit_exc != pat_mem[5*idx+4][1:0])
                begin
                    $display("FAILED at %0t: test %0d commit %0d got %0d/%h/%0d want %0d/%h/%0d",
                             $time, pat_mem[5*idx], idx, commit_dest, commit_data,
                             commit_exc, pat_mem[5*idx+2], pat_mem[5*idx+3],
                             pat_mem[5*idx+4]);
                    errors    <= errors + 1;
                    test_errs <= test_errs + 1;
                end
                // last line of this test number
                if (idx + 1 == pat_count || pat_mem[5*(idx+1)] != pat_mem[5*idx])
                begin
                    $display("test %0d: %0d commits, %0d mismatches", pat_mem[5*idx],
                             test_commits + 1, test_errs +
                             ((commit_dest != pat_mem[5*idx+2][4:0] ||
                               commit_data != pat_mem[5*idx+3] ||
                               commit_exc != pat_mem[5*idx+4][1:0]) ? 1 : 0));
                    test_errs    <= 0;
                    test_commits <= 0;
                end
                else
                begin
                    test_commits <= test_commits + 1;
                end
                idx <= idx + 1;
            end
        end
    end

endmodule

`default_nettype wire

/* bench/core_assertions.sv */
/*
 * core assertions
 *   input and commit handshakes hold until accepted
 *   register file write never targets register zero
 */
`timescale 1ns/1ps
`default_nettype none

module core_assertions
    import core_pkg::*;
(
    input wire logic      SYS_clk,
    input wire logic      SYS_reset,
    input wire logic      instr_valid,
    input wire logic      instr_ready,
    input wire word_t     instr,
    input wire logic      commit_valid,
    input wire logic      commit_ready,
    input wire reg_addr_t commit_dest,
    input wire word_t     commit_data,
    input wire exc_e      commit_exc,
    input wire logic      wr_en,
    input wire reg_addr_t wr_addr
);

    instr_hold: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        instr_valid && !instr_ready |=> instr_valid && $stable(instr))
        else $error("instr stream dropped or changed before transfer");

    commit_hold: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        commit_valid && !commit_ready |=> commit_valid && $stable(commit_dest) &&
        $stable(commit_data) && $stable(commit_exc))
        else $error("commit stream dropped or changed under back-pressure");

    no_r0_write: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        wr_en |-> wr_addr != '0)
        else $error("register file write to register zero");

endmodule

bind mips_core core_assertions u_assertions (
    .SYS_clk      (SYS_clk),
    .SYS_reset    (SYS_reset),
    .instr_valid  (instr_valid),
    .instr_ready  (instr_ready),
    .instr        (instr),
    .commit_valid (commit_valid),
    .commit_ready (commit_ready),
    .commit_dest  (commit_dest),
    .commit_data  (commit_data),
    .commit_exc   (commit_exc),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr)
);

`default_nettype wire

/* bench/tb_top.sv */
/*
 * testbench top
 *   clock, reset and the core instance
 *   instruction stream from the pattern file with random gaps
 *   random commit back-pressure, watchdog, final verdict
 */
`timescale 1ns/1ps
`default_nettype none

module tb_top
    import core_pkg::*;
();

    localparam int MAX_PAT = 64;

    logic        SYS_clk;
    logic        SYS_reset;
    logic        instr_valid;
    logic        instr_ready;
    word_t       instr;
    logic        commit_valid;
    logic        commit_ready;
    reg_addr_t   commit_dest;
    word_t       commit_data;
    exc_e        commit_exc;
    logic        report;
    logic        done;
    int          errors;
    logic [31:0] pat_mem [0:5*MAX_PAT-1];
    int          pat_count;

    mips_core u_dut (
        .SYS_clk      (SYS_clk),
        .SYS_reset    (SYS_reset),
        .instr_valid  (instr_valid),
        .instr_ready  (instr_ready),
        .instr        (instr),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit_dest  (commit_dest),
        .commit_data  (commit_data),
        .commit_exc   (commit_exc)
    );

    commit_checker u_checker (
        .SYS_clk      (SYS_clk),
        .SYS_reset    (SYS_reset),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit_dest  (commit_dest),
        .commit_data  (commit_data),
        .commit_exc   (commit_exc),
        .report       (report),
        .done         (done),
        .errors       (errors)
    );

    always #50 SYS_clk = ~SYS_clk;

    // back-pressure, low about one cycle in three
    initial
    begin
        commit_ready = 1'b0;
        forever
        begin
            @(negedge SYS_clk);
            commit_ready <= !SYS_reset && ($urandom_range(2) != 0);
        end
    end

    initial
    begin
        SYS_clk      = 1'b0;
        SYS_reset    = 1'b1;
        instr_valid  = 1'b0;
        instr        = '0;
        report       = 1'b0;
        pat_count    = 0;
        void'($urandom(32'hba086653));
        $readmemh("bench/core_patterns.txt", pat_mem);
        // list ends at a zero or unread test number
        while (pat_count < MAX_PAT && !$isunknown(pat_mem[5*pat_count]) &&
               pat_mem[5*pat_count] != '0)
        begin
            pat_count++;
        end
        repeat (4) @(posedge SYS_clk);
        @(negedge SYS_clk);
        SYS_reset = 1'b0;
        for (int i = 0; i < pat_count; i++)
        begin
            while ($urandom_range(3) == 0)
            begin
                instr_valid = 1'b0;
                @(negedge SYS_clk);
            end
            instr_valid = 1'b1;
            instr       = pat_mem[5*i+1];
            #1;
            while (!instr_ready)
            begin
                @(negedge SYS_clk);
                #1;
            end
            @(negedge SYS_clk);  // transfer took the posedge in between
        end
        instr_valid = 1'b0;
        wait (done);
        repeat (10) @(negedge SYS_clk);  // room for any extra commit
        report = 1'b1;
        @(posedge SYS_clk);
        @(negedge SYS_clk);
        if (errors == 0)
        begin
            $display("Simulation passed");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

    // 20 cycles per instruction
    initial
    begin
        @(negedge SYS_reset);
        #(longint'(pat_count) * 20 * 100);
        report = 1'b1;  // checker lists what is missing
        @(posedge SYS_clk);
        @(negedge SYS_clk);
        $display("watchdog timeout: not all instructions committed in time");
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/core_patterns.txt */
// test  instr     dest  data      exc   (all hex)
// exc 0 none, 1 illegal, 2 overflow; registers start at zero
1 20010005 01 00000005 0
1 20020003 02 00000003 0
1 2003000c 03 0000000c 0
1 00222020 04 00000008 0
1 00612822 05 00000007 0
1 00613024 06 00000004 0
1 00613825 07 0000000d 0
1 0041402a 08 00000001 0
2 2009fffc 09 fffffffc 0
2 0121502a 0a 00000001 0
2 0029582a 0b 00000000 0
3 202c0001 0c 00000006 0
3 018c6820 0d 0000000c 0
3 01ac7022 0e 00000006 0
4 200f7fff 0f 00007fff 0
4 01ef7820 0f 0000fffe 0
4 01ef7820 0f 0001fffc 0
4 01ef7820 0f 0003fff8 0
4 01ef7820 0f 0007fff0 0
4 01ef7820 0f 000fffe0 0
4 01ef7820 0f 001fffc0 0
4 01ef7820 0f 003fff80 0
4 01ef7820 0f 007fff00 0
4 01ef7820 0f 00fffe00 0
4 01ef7820 0f 01fffc00 0
4 01ef7820 0f 03fff800 0
4 01ef7820 0f 07fff000 0
4 01ef7820 0f 0fffe000 0
4 01ef7820 0f 1fffc000 0
4 01ef7820 0f 3fff8000 0
4 01ef7820 0f 7fff0000 0
4 01ef7820 0f 00000000 2
4 01e08825 11 7fff0000 0
5 fc000000 00 00000000 1
5 20200007 00 0000000c 0
5 00009025 12 00000000 0
6 20130064 13 00000064 0
6 0269a020 14 00000060 0
6 0293a822 15 fffffffc 0

/* tb.f */
source/core_pkg.sv
source/pipe_ifs.sv
source/reg_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/writeback_stage.sv
source/mips_core.sv
bench/commit_checker.sv
bench/core_assertions.sv
bench/tb_top.sv

/* Makefile */
SRCS := $(wildcard source/*.sv bench/*.sv)

.PHONY: run clean

obj_dir/Vtb_top: tb.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_top -f tb.f -o Vtb_top

run: obj_dir/Vtb_top bench/core_patterns.txt
	./obj_dir/Vtb_top | tee sim.log
	@if grep -q "Simulation failed" sim.log; then exit 1; fi
	@grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log
